// ==== logic/adc_app_defs.svh ====
`ifndef ADC_APP_DEFS_SVH
`define ADC_APP_DEFS_SVH

//////////////////////////////
// Widths
//////////////////////////////

// DSP bus
`define ADC_BUS_AW 8
`define ADC_BUS_DW 16

// Converter samples, fast 4-channel part and 24-bit sigma-delta part
`define ADC_FAST_W 16
`define ADC_PREC_W 24

// Register read data from the sigma-delta controller
`define ADC_RDATA_W 32

// Command fields
`define ADC_ACT_W  4
`define ADC_COMM_W 8
`define ADC_FLTR_W 16

//////////////////////////////
// Bus addresses
//////////////////////////////

// Write side
`define ADC_WR_CAPTURE      8'h0E
`define ADC_WR_CAPTURE_MODE 8'h0F
`define ADC_WR_FLTR_CLK     8'h10
`define ADC_WR_AD7175_CMD   8'h11
`define ADC_WR_AD7175_MS    8'h12
`define ADC_WR_AD7175_LS    8'h13

// Read side, fast channels first
`define ADC_RD_A1 8'h13
`define ADC_RD_A2 8'h14
`define ADC_RD_A3 8'h15
`define ADC_RD_A4 8'h16
// Upper 16 bits of the precise channels
`define ADC_RD_A5 8'h17
`define ADC_RD_A6 8'h18
`define ADC_RD_A7 8'h19
`define ADC_RD_A8 8'h1A
`define ADC_RD_STATUS  8'h22
`define ADC_RD_DATA_MS 8'h23
`define ADC_RD_DATA_LS 8'h24

//////////////////////////////
// Codes and counts
//////////////////////////////

// Turns off the continuous conversion reader
`define ADC_ACT_CC_RESET 4'h8

// Mode bit value for timer driven capture
`define ADC_CAPTURE_MODE_AUTO 1'b1

// Auto timer wraps here, 1127 cycles per period
`define ADC_CAPTURE_AUTO_MAX 11'h466
`define ADC_CAPTURE_BIT      10

`endif

// ==== logic/adc_app_pkg.sv ====
`default_nettype none

`include "adc_app_defs.svh"

package adc_app_pkg;

	// Qualified DSP bus cycle
	typedef struct packed {
		logic                   wr;
		logic                   rd;
		logic [`ADC_BUS_AW-1:0] addr;
		logic [`ADC_BUS_DW-1:0] data;
	} bus_req_t;

	// Capture and filter setup from the DSP
	typedef struct packed {
		// 1 selects the auto timer
		logic                    mode;
		logic                    manual;
		logic [`ADC_FLTR_W-1:0]  fltr_div;
	} capture_cfg_t;

	// Command to the sigma-delta controller
	typedef struct packed {
		logic                    start;
		logic [`ADC_ACT_W-1:0]   action;
		// Communications register byte
		logic [`ADC_COMM_W-1:0]  comm;
		logic [`ADC_PREC_W-1:0]  wdata;
	} ad7175_cmd_t;

	// Status back from the sigma-delta controller
	typedef struct packed {
		logic                    ctrl_busy;
		// Continuous conversion reader running
		logic                    cc_read_busy;
		logic [`ADC_RDATA_W-1:0] rdata;
	} ad7175_stat_t;

	// Latest samples of all eight channels
	typedef struct packed {
		logic [3:0][`ADC_FAST_W-1:0] fast;
		logic [3:0][`ADC_PREC_W-1:0] prec;
	} sample_set_t;

endpackage

`default_nettype wire

// ==== logic/adc_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_app_defs.svh"

module adc_bus_decode (
	input  wire                        xclk,
	input  wire                        reset,
	input  wire adc_app_pkg::bus_req_t bus,
	output adc_app_pkg::capture_cfg_t  cfg,
	output adc_app_pkg::ad7175_cmd_t   req
);

	// Command payload registers
	logic                   start_q;
	logic [`ADC_ACT_W-1:0]  action_q;
	logic [`ADC_COMM_W-1:0] comm_q;
	logic [7:0]             data_ms_q;
	logic [15:0]            data_ls_q;

	// Write hits on the command words
	logic wr_cmd;
	logic wr_ms;
	logic wr_ls;

	assign wr_cmd = bus.wr && (bus.addr == `ADC_WR_AD7175_CMD);
	assign wr_ms  = bus.wr && (bus.addr == `ADC_WR_AD7175_MS);
	assign wr_ls  = bus.wr && (bus.addr == `ADC_WR_AD7175_LS);

	//////////////////////////////
	// Configuration
	//////////////////////////////

	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			// Auto capture out of reset
			cfg.mode     <= `ADC_CAPTURE_MODE_AUTO;
			cfg.manual   <= 1'b0;
			cfg.fltr_div <= '0;
			start_q      <= 1'b0;
		end else begin
			// One cycle request that clears on any other cycle
			start_q <= wr_cmd;
			if (bus.wr) begin
				case (bus.addr)
					`ADC_WR_CAPTURE:      cfg.manual   <= bus.data[0];
					`ADC_WR_CAPTURE_MODE: cfg.mode     <= bus.data[0];
					`ADC_WR_FLTR_CLK:     cfg.fltr_div <= bus.data;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// Command fields
	//////////////////////////////

	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			comm_q    <= '0;
			action_q  <= '0;
			data_ms_q <= '0;
			data_ls_q <= '0;
		end else begin
			if (wr_cmd) begin
				// Comm byte low and action code in bits 11:8
				comm_q   <= bus.data[`ADC_COMM_W-1:0];
				action_q <= bus.data[`ADC_COMM_W +: `ADC_ACT_W];
			end
			if (wr_ms) begin
				data_ms_q <= bus.data[7:0];
			end
			if (wr_ls) begin
				data_ls_q <= bus.data;
			end
		end
	end

	assign req.start  = start_q;
	assign req.action = action_q;
	assign req.comm   = comm_q;
	// Right justified 24-bit write word
	assign req.wdata  = {data_ms_q, data_ls_q};

endmodule

`default_nettype wire

// ==== logic/adc_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_app_defs.svh"

module adc_clock_gen (
	input  wire                            xclk,
	input  wire                            reset,
	input  wire adc_app_pkg::capture_cfg_t cfg,
	output logic                           capture_one,
	output logic                           fltr_clk
);

	logic [10:0]           auto_cnt;
	logic [`ADC_FLTR_W:0]  fltr_cnt;
	logic                  auto_mode;

	assign auto_mode = (cfg.mode == `ADC_CAPTURE_MODE_AUTO);

	//////////////////////////////
	// Capture tick
	//////////////////////////////

	// Free running in auto mode, parked at zero in manual mode
	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			auto_cnt <= '0;
		end else if (!auto_mode || (auto_cnt == `ADC_CAPTURE_AUTO_MAX)) begin
			auto_cnt <= '0;
		end else begin
			auto_cnt <= auto_cnt + 1'b1;
		end
	end

	// Upper timer bit gives a short pulse each period
	assign capture_one = auto_mode ? auto_cnt[`ADC_CAPTURE_BIT] : cfg.manual;

	//////////////////////////////
	// Filter clock
	//////////////////////////////

	// Reload 2*div+1, toggle on zero
	// Half period is 2*div+2 cycles
	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			fltr_cnt <= '0;
			fltr_clk <= 1'b0;
		end else if (fltr_cnt == '0) begin
			fltr_cnt <= {cfg.fltr_div, 1'b1};
			fltr_clk <= ~fltr_clk;
		end else begin
			fltr_cnt <= fltr_cnt - 1'b1;
		end
	end

	// Timer stays inside its wrap range
	a_auto_range: assert property (
		@(posedge xclk) disable iff (!reset)
		auto_cnt <= `ADC_CAPTURE_AUTO_MAX
	);

endmodule

`default_nettype wire

// ==== logic/ad7175_cmd_launch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_app_defs.svh"

module ad7175_cmd_launch (
	input  wire                            xclk,
	input  wire                            reset,
	input  wire adc_app_pkg::ad7175_cmd_t  req,
	input  wire adc_app_pkg::ad7175_stat_t stat,
	output adc_app_pkg::ad7175_cmd_t       cmd
);

	logic start_q;
	logic is_cc_reset;
	logic grant;

	assign is_cc_reset = (req.action == `ADC_ACT_CC_RESET);

	// Reset only makes sense while the reader runs
	// Anything else needs an idle controller
	assign grant = is_cc_reset ? stat.cc_read_busy : !stat.ctrl_busy;

	// Held until the controller answers with busy
	// Denied requests are simply lost
	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			start_q <= 1'b0;
		end else if (req.start) begin
			if (grant) begin
				start_q <= 1'b1;
			end
		end else if (stat.ctrl_busy) begin
			start_q <= 1'b0;
		end
	end

	assign cmd.start  = start_q;
	assign cmd.action = req.action;
	assign cmd.comm   = req.comm;
	assign cmd.wdata  = req.wdata;

	// No launch out of a refused request
	a_no_denied_start: assert property (
		@(posedge xclk) disable iff (!reset)
		(req.start && !grant) |=> !$rose(cmd.start)
	);

	// Busy acknowledge drops the strobe next cycle
	a_busy_clears: assert property (
		@(posedge xclk) disable iff (!reset)
		(cmd.start && stat.ctrl_busy && !req.start) |=> !cmd.start
	);

endmodule

`default_nettype wire

// ==== logic/adc_readback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_app_defs.svh"

module adc_readback (
	input  wire                            xclk,
	input  wire                            reset,
	input  wire adc_app_pkg::bus_req_t     bus,
	input  wire adc_app_pkg::sample_set_t  samples,
	input  wire adc_app_pkg::ad7175_stat_t stat,
	output logic [`ADC_BUS_DW-1:0]         db_out,
	output logic                           data_avail
);

	localparam int PREC_TOP = `ADC_PREC_W - 1;

	// Status word, two busy flags at the bottom
	logic [`ADC_BUS_DW-1:0] status_word;

	assign status_word = {{(`ADC_BUS_DW-2){1'b0}}, stat.cc_read_busy, stat.ctrl_busy};

	//////////////////////////////
	// Read mux
	//////////////////////////////

	// Loaded on the read strobe, held until the next read
	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			db_out     <= '0;
			data_avail <= 1'b0;
		end else if (bus.rd) begin
			data_avail <= 1'b1;
			case (bus.addr)
				// Fast channels fit the bus as they are
				`ADC_RD_A1: db_out <= samples.fast[0];
				`ADC_RD_A2: db_out <= samples.fast[1];
				`ADC_RD_A3: db_out <= samples.fast[2];
				`ADC_RD_A4: db_out <= samples.fast[3];
				// Precise channels, top 16 bits only
				`ADC_RD_A5: db_out <= samples.prec[0][PREC_TOP -: `ADC_BUS_DW];
				`ADC_RD_A6: db_out <= samples.prec[1][PREC_TOP -: `ADC_BUS_DW];
				`ADC_RD_A7: db_out <= samples.prec[2][PREC_TOP -: `ADC_BUS_DW];
				`ADC_RD_A8: db_out <= samples.prec[3][PREC_TOP -: `ADC_BUS_DW];
				`ADC_RD_STATUS: db_out <= status_word;
				// Register read data in two halves
				`ADC_RD_DATA_MS: db_out <= stat.rdata[`ADC_RDATA_W-1 -: `ADC_BUS_DW];
				`ADC_RD_DATA_LS: db_out <= stat.rdata[`ADC_BUS_DW-1:0];
				default: begin
					// Not ours, nothing valid to hand back
					db_out     <= '1;
					data_avail <= 1'b0;
				end
			endcase
		end
	end

	// Data flag only follows a read cycle
	a_avail_needs_read: assert property (
		@(posedge xclk) disable iff (!reset)
		$rose(data_avail) |-> $past(bus.rd)
	);

endmodule

`default_nettype wire

// ==== logic/adc_app_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_app_defs.svh"

module adc_app_top (
	input  wire                            xclk,
	input  wire                            reset,
	input  wire adc_app_pkg::bus_req_t     bus,
	input  wire adc_app_pkg::sample_set_t  samples,
	input  wire adc_app_pkg::ad7175_stat_t stat,
	output wire [`ADC_BUS_DW-1:0]          db_out,
	output wire                            data_avail,
	output adc_app_pkg::ad7175_cmd_t       cmd,
	output wire                            capture_one,
	output wire                            fltr_clk
);

	// Decoder to clock generator and launcher
	adc_app_pkg::capture_cfg_t cfg;
	adc_app_pkg::ad7175_cmd_t  req;

	//////////////////////////////
	// Blocks
	//////////////////////////////

	adc_bus_decode decode_i (
		.xclk  (xclk),
		.reset (reset),
		.bus   (bus),
		.cfg   (cfg),
		.req   (req)
	);

	adc_clock_gen clock_gen_i (
		.xclk        (xclk),
		.reset       (reset),
		.cfg         (cfg),
		.capture_one (capture_one),
		.fltr_clk    (fltr_clk)
	);

	// Start strobe toward the sigma-delta controller
	ad7175_cmd_launch launch_i (
		.xclk  (xclk),
		.reset (reset),
		.req   (req),
		.stat  (stat),
		.cmd   (cmd)
	);

	adc_readback readback_i (
		.xclk       (xclk),
		.reset      (reset),
		.bus        (bus),
		.samples    (samples),
		.stat       (stat),
		.db_out     (db_out),
		.data_avail (data_avail)
	);

endmodule

`default_nettype wire

// ==== tb/adc_app_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_app_defs.svh"

module adc_app_tb;

	typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_LAUNCH, OP_CAPTURE, OP_FILTER} op_t;

	// One table row
	// flags bit 0 drives cc_read_busy and bit 1 forces ctrl_busy high
	typedef struct {
		string       name;
		op_t         op;
		logic [1:0]  flags;
		logic [7:0]  addr;
		logic [15:0] data;
		logic [39:0] exp_val;
	} entry_t;

	localparam int SEL_START   = 0;
	localparam int SEL_BUSY    = 1;
	localparam int SEL_CAPTURE = 2;
	// Controller stays busy this long after it takes a start
	localparam int BUSY_CYCLES = 6;
	// Write data built from the MS word 0x00A5 and the LS word 0x3C96
	localparam logic [23:0] WDATA = 24'hA53C96;

	logic                      xclk;
	logic                      reset;
	adc_app_pkg::bus_req_t     bus;
	adc_app_pkg::sample_set_t  samples;
	adc_app_pkg::ad7175_stat_t stat;
	logic [`ADC_BUS_DW-1:0]    db_out;
	logic                      data_avail;
	adc_app_pkg::ad7175_cmd_t  cmd;
	logic                      capture_one;
	logic                      fltr_clk;

	// Controller model state
	logic                    cc_busy;
	logic                    hold_busy;
	logic                    model_busy = 1'b0;
	logic [`ADC_RDATA_W-1:0] rdata_v;
	int                      busy_left = 0;
	int                      start_age = 0;

	logic [15:0] lfsr = 16'd98;
	entry_t      tests[$];
	logic        test_ok;
	int          pass_cnt = 0;
	int          fail_cnt = 0;

	// Forced busy overrides the model
	assign stat = {model_busy | hold_busy, cc_busy, rdata_v};

	adc_app_top dut_i (
		.xclk        (xclk),
		.reset       (reset),
		.bus         (bus),
		.samples     (samples),
		.stat        (stat),
		.db_out      (db_out),
		.data_avail  (data_avail),
		.cmd         (cmd),
		.capture_one (capture_one),
		.fltr_clk    (fltr_clk)
	);

	initial begin
		xclk = 1'b0;
		forever #2 xclk = ~xclk;
	end

	//////////////////////////////
	// Controller model
	//////////////////////////////

	// Busy two cycles after start shows up and low again after BUSY_CYCLES
	always @(posedge xclk) begin
		#1;
		if (!reset) begin
			model_busy = 1'b0;
			busy_left  = 0;
			start_age  = 0;
		end else if (busy_left != 0) begin
			busy_left  = busy_left - 1;
			model_busy = (busy_left != 0);
		end else if (cmd.start) begin
			start_age = start_age + 1;
			if (start_age == 2) begin
				model_busy = 1'b1;
				busy_left  = BUSY_CYCLES;
				start_age  = 0;
			end
		end else begin
			start_age = 0;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// n bits with one LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	// Inputs change here
	task drive_point();
		@(posedge xclk);
		#1;
	endtask

	// Outputs are read here half a cycle away from any change
	task sample_point();
		@(negedge xclk);
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			SEL_START: return cmd.start;
			SEL_BUSY:  return stat.ctrl_busy;
			default:   return capture_one;
		endcase
	endfunction

	task automatic wait_for(input int sel, input logic level, input int limit, output logic ok);
		int n;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < limit) begin
			sample_point();
			n++;
			if (probe(sel) === level) ok = 1'b1;
		end
	endtask

	// Cycles from the current fltr_clk level to its next change
	task automatic toggle_gap(output int n, output logic ok);
		logic cur;
		cur = fltr_clk;
		n   = 0;
		ok  = 1'b0;
		while (!ok && n < 100) begin
			sample_point();
			n++;
			if (fltr_clk !== cur) ok = 1'b1;
		end
	endtask

	task automatic check_value(input string name, input logic [39:0] exp_v,
			input logic [39:0] got);
		assert (got === exp_v) else begin
			$display("Fail %s: expected %h, got %h", name, exp_v, got);
			test_ok = 1'b0;
		end
	endtask

	task automatic check_done(input string name, input logic ok, input string what);
		assert (ok) else begin
			$display("Timeout in %s, %s", name, what);
			test_ok = 1'b0;
		end
	endtask

	task automatic log_result(input string name);
		if (test_ok) begin
			pass_cnt++;
			$display("[ok]    %s", name);
		end else begin
			fail_cnt++;
			$display("[error] %s", name);
		end
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
		bus.wr   = 1'b1;
		bus.rd   = 1'b0;
		bus.addr = addr;
		bus.data = data;
		drive_point();
		bus = '0;
	endtask

	task automatic bus_read(input logic [7:0] addr);
		bus.wr   = 1'b0;
		bus.rd   = 1'b1;
		bus.addr = addr;
		bus.data = '0;
		drive_point();
		bus = '0;
	endtask

	//////////////////////////////
	// Test table
	//////////////////////////////

	function automatic void add_entry(input string name, input op_t op, input logic [1:0] flags,
			input logic [7:0] addr, input logic [15:0] data, input logic [39:0] exp_val);
		entry_t e;
		e.name    = name;
		e.op      = op;
		e.flags   = flags;
		e.addr    = addr;
		e.data    = data;
		e.exp_val = exp_val;
		tests.push_back(e);
	endfunction

	function automatic void build_tests();
		logic [7:0]  rd_addr [8];
		logic [15:0] word;
		logic [15:0] cc_cmd;
		int          i;
		int          div;
		int          gap;
		int          period;
		int          high;
		rd_addr[0] = `ADC_RD_A1;
		rd_addr[1] = `ADC_RD_A2;
		rd_addr[2] = `ADC_RD_A3;
		rd_addr[3] = `ADC_RD_A4;
		rd_addr[4] = `ADC_RD_A5;
		rd_addr[5] = `ADC_RD_A6;
		rd_addr[6] = `ADC_RD_A7;
		rd_addr[7] = `ADC_RD_A8;
		// Fast channels in full and precise channels by their top 16 bits
		for (i = 0; i < 8; i++) begin
			if (i < 4) word = samples.fast[i];
			else word = samples.prec[i-4][`ADC_PREC_W-1 -: 16];
			add_entry($sformatf("read_a%0d", i + 1), OP_READ, 2'b00, rd_addr[i], 16'h0,
				{23'd0, 1'b1, word});
		end
		// Status word with cc_read_busy in bit 1 and ctrl_busy in bit 0
		add_entry("read_status_cc", OP_READ, 2'b01, `ADC_RD_STATUS, 16'h0, {23'd0, 1'b1, 16'h0002});
		add_entry("read_status_ctrl", OP_READ, 2'b10, `ADC_RD_STATUS, 16'h0, {23'd0, 1'b1, 16'h0001});
		add_entry("read_data_ms", OP_READ, 2'b00, `ADC_RD_DATA_MS, 16'h0,
			{23'd0, 1'b1, rdata_v[31:16]});
		add_entry("read_data_ls", OP_READ, 2'b00, `ADC_RD_DATA_LS, 16'h0,
			{23'd0, 1'b1, rdata_v[15:0]});
		add_entry("read_unknown", OP_READ, 2'b00, 8'h40, 16'h0, {23'd0, 1'b0, 16'hFFFF});
		// Command word carries the action in bits 11:8 and the comm byte below
		cc_cmd = {4'h0, `ADC_ACT_CC_RESET, 8'h17};
		add_entry("write_data_ms", OP_WRITE, 2'b00, `ADC_WR_AD7175_MS, 16'h00A5, 40'd0);
		add_entry("write_data_ls", OP_WRITE, 2'b00, `ADC_WR_AD7175_LS, 16'h3C96, 40'd0);
		add_entry("launch_read", OP_LAUNCH, 2'b00, `ADC_WR_AD7175_CMD, 16'h0245,
			{3'd0, 1'b1, 4'h2, 8'h45, WDATA});
		add_entry("deny_cc_reset", OP_LAUNCH, 2'b00, `ADC_WR_AD7175_CMD, cc_cmd, 40'd0);
		add_entry("deny_busy", OP_LAUNCH, 2'b10, `ADC_WR_AD7175_CMD, 16'h0233, 40'd0);
		add_entry("launch_cc_reset", OP_LAUNCH, 2'b01, `ADC_WR_AD7175_CMD, cc_cmd,
			{3'd0, 1'b1, `ADC_ACT_CC_RESET, 8'h17, WDATA});
		// Manual capture follows the written bit
		add_entry("manual_mode", OP_WRITE, 2'b00, `ADC_WR_CAPTURE_MODE, 16'h0000, 40'd0);
		for (i = 0; i < 4; i++) begin
			add_entry($sformatf("manual_bit_%0d", i), OP_CAPTURE, 2'b00, `ADC_WR_CAPTURE,
				{15'd0, ~i[0]}, {39'd0, ~i[0]});
		end
		// Timer wraps at the terminal count and the tick is high from 1024 to the wrap
		period = `ADC_CAPTURE_AUTO_MAX + 1;
		high   = period - (1 << `ADC_CAPTURE_BIT);
		add_entry("auto_capture", OP_CAPTURE, 2'b00, `ADC_WR_CAPTURE_MODE, 16'h0001,
			{8'd0, high[15:0], period[15:0]});
		// Half period of the filter clock is 2*d+2
		for (i = 0; i < 2; i++) begin
			div = (i == 0) ? 3 : 10;
			gap = 2 * div + 2;
			add_entry($sformatf("filter_div_%0d", div), OP_FILTER, 2'b00, `ADC_WR_FLTR_CLK,
				div[15:0], {24'd0, gap[15:0]});
		end
	endfunction

	//////////////////////////////
	// Test steps
	//////////////////////////////

	task automatic run_launch(input entry_t e);
		logic ok;
		int   i;
		bus_write(e.addr, e.data);
		if (e.exp_val[36]) begin
			wait_for(SEL_START, 1'b1, 20, ok);
			check_done(e.name, ok, "the start strobe never rose");
			if (ok) begin
				check_value(e.name, e.exp_val, {3'd0, cmd});
				wait_for(SEL_BUSY, 1'b1, 20, ok);
				check_done(e.name, ok, "the controller never went busy");
				// Start drops on the edge that sees busy
				sample_point();
				check_value(e.name, 40'd0, {39'd0, cmd.start});
				wait_for(SEL_BUSY, 1'b0, 40, ok);
				check_done(e.name, ok, "the controller stayed busy");
			end
		end else begin
			// Denied request must never show up as a start
			i = 0;
			while (test_ok && i < 20) begin
				sample_point();
				check_value(e.name, 40'd0, {39'd0, cmd.start});
				i++;
			end
		end
	endtask

	task automatic run_capture(input entry_t e);
		logic        ok;
		logic        prev;
		logic [15:0] high_cnt;
		logic [15:0] period_cnt;
		bus_write(e.addr, e.data);
		if (e.addr == `ADC_WR_CAPTURE_MODE) begin
			// First rise after leaving manual mode and then one full period
			wait_for(SEL_CAPTURE, 1'b1, 1200, ok);
			check_done(e.name, ok, "the auto capture tick never came");
			high_cnt   = 16'd1;
			period_cnt = 16'd0;
			prev       = 1'b1;
			ok         = 1'b0;
			while (!ok && period_cnt < 16'd2000) begin
				sample_point();
				period_cnt = period_cnt + 16'd1;
				if (capture_one && !prev) ok = 1'b1;
				else if (capture_one) high_cnt = high_cnt + 16'd1;
				prev = capture_one;
			end
			check_done(e.name, ok, "the second auto capture tick never came");
			check_value(e.name, e.exp_val, {8'd0, high_cnt, period_cnt});
		end else begin
			sample_point();
			check_value(e.name, e.exp_val, {39'd0, capture_one});
		end
	endtask

	task automatic run_filter(input entry_t e);
		logic ok;
		int   n;
		int   k;
		bus_write(e.addr, e.data);
		// First toggle may still close a period of the old divisor
		toggle_gap(n, ok);
		check_done(e.name, ok, "the filter clock stopped");
		for (k = 0; k < 2; k++) begin
			toggle_gap(n, ok);
			check_done(e.name, ok, "the filter clock stopped");
			check_value(e.name, e.exp_val, {24'd0, n[15:0]});
		end
	endtask

	task automatic run_entry(input entry_t e);
		test_ok = 1'b1;
		drive_point();
		cc_busy   = e.flags[0];
		hold_busy = e.flags[1];
		case (e.op)
			OP_READ: begin
				bus_read(e.addr);
				sample_point();
				check_value(e.name, e.exp_val, {23'd0, data_avail, db_out});
			end
			OP_LAUNCH:  run_launch(e);
			OP_CAPTURE: run_capture(e);
			OP_FILTER:  run_filter(e);
			default:    bus_write(e.addr, e.data);
		endcase
		log_result(e.name);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		reset     = 1'b0;
		bus       = '0;
		cc_busy   = 1'b0;
		hold_busy = 1'b0;
		load_samples();
		build_tests();
		// Reset held for 10 edges with outputs checked just before release
		repeat (9) @(posedge xclk);
		sample_point();
		test_ok = 1'b1;
		check_value("reset_state", 40'd0,
			{20'd0, db_out, data_avail, cmd.start, capture_one, fltr_clk});
		drive_point();
		reset = 1'b1;
		log_result("reset_state");
		foreach (tests[k]) run_entry(tests[k]);
		$display("checks: %0d good, %0d bad", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Samples and read data from the LFSR
	task automatic load_samples();
		logic [31:0] r;
		int i;
		for (i = 0; i < 4; i++) begin
			r = rand_bits(`ADC_FAST_W);
			samples.fast[i] = r[`ADC_FAST_W-1:0];
			r = rand_bits(`ADC_PREC_W);
			samples.prec[i] = r[`ADC_PREC_W-1:0];
		end
		rdata_v = rand_bits(`ADC_RDATA_W);
	endtask

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/adc_app_pkg.sv
logic/adc_bus_decode.sv
logic/adc_clock_gen.sv
logic/ad7175_cmd_launch.sv
logic/adc_readback.sv
logic/adc_app_top.sv
tb/adc_app_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module adc_app_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete"
	exit 1
fi

sim_out=$(./obj_dir/Vadc_app_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
